/* hyper_pkg.sv */
package hyper_pkg;

    localparam int DataWidth      = 16;
    localparam int AddrWidth      = 16;
    localparam int LenWidth       = 4;
    localparam int RecoveryCycles = 2;
    localparam int CmdWriteBit    = 7;

    typedef logic [DataWidth-1:0] word_t;
    typedef logic [AddrWidth-1:0] addr_t;
    // Burst length in words minus one
    typedef logic [LenWidth-1:0]  len_t;

    typedef struct packed {
        logic  write;
        addr_t addr;
        len_t  len;
    } trans_t;

    typedef struct packed {
        word_t data;
        logic  last;
    } tx_beat_t;

    typedef struct packed {
        word_t data;
        logic  last;
    } rx_beat_t;

    typedef enum logic {
        REQ_SYS,
        REQ_DMA
    } req_sel_e;

    typedef enum logic [2:0] {
        PHY_IDLE,
        PHY_CMD,
        PHY_LATENCY,
        PHY_WDATA,
        PHY_RDATA,
        PHY_RECOVER
    } phy_state_e;

endpackage

/* hyper_port_if.sv */
interface hyper_port_if;

    // Transaction stream
    logic                trans_valid;
    logic                trans_ready;
    hyper_pkg::trans_t   trans;

    // Write data stream
    logic                tx_valid;
    logic                tx_ready;
    hyper_pkg::tx_beat_t tx;

    // Read data stream
    logic                rx_valid;
    logic                rx_ready;
    hyper_pkg::rx_beat_t rx;

    modport host (
        output trans_valid, trans, tx_valid, tx, rx_ready,
        input  trans_ready, tx_ready, rx_valid, rx
    );

    modport bus (
        input  trans_valid, trans, tx_valid, tx, rx_ready,
        output trans_ready, tx_ready, rx_valid, rx
    );

endinterface

/* hyper_host_port.sv */
module hyper_host_port (
    input  logic                clk_sys_i,
    input  logic                rst_n_i,
    input  logic                trans_valid_i,
    output logic                trans_ready_o,
    input  hyper_pkg::trans_t   trans_i,
    input  logic                tx_valid_i,
    output logic                tx_ready_o,
    input  hyper_pkg::word_t    tx_data_i,
    output logic                rx_valid_o,
    input  logic                rx_ready_i,
    output hyper_pkg::rx_beat_t rx_o,
    hyper_port_if.host          port
);

    hyper_pkg::trans_t trans_q;
    hyper_pkg::len_t   cnt_q;
    logic              pending_q;
    logic              pending_d;
    logic              wr_open_q;
    logic              wr_open_d;
    logic              ready_q;
    logic              trans_hs;
    logic              tx_hs;
    logic              tx_last;

    assign trans_hs = trans_valid_i && ready_q;
    assign tx_hs    = port.tx_valid && port.tx_ready;
    assign tx_last  = cnt_q == trans_q.len;

    always_comb begin
        pending_d = pending_q;
        wr_open_d = wr_open_q;
        if (port.trans_valid && port.trans_ready) begin
            pending_d = 1'b0;
        end
        if (tx_hs && tx_last) begin
            wr_open_d = 1'b0;
        end
        if (trans_hs) begin
            pending_d = 1'b1;
            wr_open_d = trans_i.write;
        end
    end

    always_ff @(posedge clk_sys_i) begin
        if (!rst_n_i) begin
            pending_q <= 1'b0;
            wr_open_q <= 1'b0;
            ready_q   <= 1'b0;
            cnt_q     <= '0;
        end else begin
            pending_q <= pending_d;
            wr_open_q <= wr_open_d;
            // One transaction held at a time
            ready_q   <= !pending_d && !wr_open_d;
            if (trans_hs) begin
                cnt_q <= '0;
            end else if (tx_hs) begin
                cnt_q <= cnt_q + 1'b1;
            end
        end
    end

    always_ff @(posedge clk_sys_i) begin
        if (trans_hs) begin
            trans_q <= trans_i;
        end
    end

    assign trans_ready_o    = ready_q;
    assign port.trans_valid = pending_q;
    assign port.trans       = trans_q;

    // Write beats flow only while the write is open
    assign port.tx_valid    = tx_valid_i && wr_open_q;
    assign port.tx.data     = tx_data_i;
    assign port.tx.last     = tx_last;
    assign tx_ready_o       = port.tx_ready && wr_open_q;

    assign rx_valid_o       = port.rx_valid;
    assign rx_o             = port.rx;
    assign port.rx_ready    = rx_ready_i;

endmodule

/* hyper_arbiter.sv */
module hyper_arbiter (
    input  logic       clk_sys_i,
    input  logic       rst_n_i,
    hyper_port_if.bus  sys,
    hyper_port_if.bus  dma,
    hyper_port_if.host phy
);

    hyper_pkg::req_sel_e grant_q;
    logic                lock_q;
    logic                wr_q;
    logic                served_q;
    logic                sel_dma;
    logic                cur_valid;
    logic                other_valid;
    logic                trans_hs;
    logic                trans_end;

    assign sel_dma     = grant_q == hyper_pkg::REQ_DMA;
    assign cur_valid   = sel_dma ? dma.trans_valid : sys.trans_valid;
    assign other_valid = sel_dma ? sys.trans_valid : dma.trans_valid;

    // Toward the PHY, from the granted port
    assign phy.trans_valid = cur_valid && !lock_q;
    assign phy.trans       = sel_dma ? dma.trans : sys.trans;
    assign phy.tx_valid    = sel_dma ? dma.tx_valid : sys.tx_valid;
    assign phy.tx          = sel_dma ? dma.tx : sys.tx;
    assign phy.rx_ready    = sel_dma ? dma.rx_ready : sys.rx_ready;

    assign sys.trans_ready = !sel_dma && !lock_q && phy.trans_ready;
    assign dma.trans_ready = sel_dma && !lock_q && phy.trans_ready;
    assign sys.tx_ready    = !sel_dma && phy.tx_ready;
    assign dma.tx_ready    = sel_dma && phy.tx_ready;

    // Read data reaches the granted port only
    assign sys.rx_valid    = !sel_dma && phy.rx_valid;
    assign dma.rx_valid    = sel_dma && phy.rx_valid;
    assign sys.rx          = phy.rx;
    assign dma.rx          = phy.rx;

    assign trans_hs  = phy.trans_valid && phy.trans_ready;
    assign trans_end = lock_q && (wr_q ?
                       (phy.tx_valid && phy.tx_ready && phy.tx.last) :
                       (phy.rx_valid && phy.rx_ready && phy.rx.last));

    always_ff @(posedge clk_sys_i) begin
        if (!rst_n_i) begin
            grant_q  <= hyper_pkg::REQ_SYS;
            lock_q   <= 1'b0;
            wr_q     <= 1'b0;
            served_q <= 1'b0;
        end else begin
            if (trans_hs) begin
                lock_q <= 1'b1;
                wr_q   <= phy.trans.write;
            end else if (trans_end) begin
                lock_q   <= 1'b0;
                served_q <= 1'b1;
            end else if (!lock_q && other_valid && (served_q || !cur_valid)) begin
                // Hand over once the current side has had its turn
                grant_q  <= sel_dma ? hyper_pkg::REQ_SYS : hyper_pkg::REQ_DMA;
                served_q <= 1'b0;
            end
        end
    end

endmodule

/* hyper_phy.sv */
module hyper_phy #(
    parameter int unsigned LatencyCycles = 4
) (
    input  logic       clk_sys_i,
    input  logic       rst_n_i,
    hyper_port_if.bus  port,
    output logic       hyper_cs_n_o,
    output logic       hyper_ck_o,
    output logic [7:0] hyper_dq_o,
    output logic       hyper_dq_oe_o,
    input  logic [7:0] hyper_dq_i
);

    localparam int unsigned CntWidth =
        $clog2(LatencyCycles + hyper_pkg::RecoveryCycles + 4);

    hyper_pkg::phy_state_e state_q;
    hyper_pkg::trans_t     trans_q;
    hyper_pkg::len_t       wcnt_q;
    hyper_pkg::rx_beat_t   rx_q;
    logic [CntWidth-1:0]   cnt_q;
    logic                  half_q;
    logic                  cs_n_q;
    logic                  ck_q;
    logic                  oe_q;
    logic                  rx_valid_q;
    logic [7:0]            dq_q;
    logic [7:0]            dq_d;
    // Low write byte, or high read byte already sampled
    logic [7:0]            byte_q;
    logic                  trans_hs;
    logic                  tx_hs;
    logic                  rd_hi;
    logic                  rd_lo;
    logic                  rd_last;
    logic                  rx_free;

    assign port.trans_ready = state_q == hyper_pkg::PHY_IDLE;
    assign port.tx_ready    = state_q == hyper_pkg::PHY_WDATA && !half_q;
    assign port.rx_valid    = rx_valid_q;
    assign port.rx          = rx_q;

    assign trans_hs = port.trans_valid && port.trans_ready;
    assign tx_hs    = port.tx_valid && port.tx_ready;
    assign rd_hi    = state_q == hyper_pkg::PHY_RDATA && ck_q && !half_q;
    assign rd_lo    = state_q == hyper_pkg::PHY_RDATA && ck_q && half_q;
    assign rd_last  = wcnt_q == trans_q.len;
    assign rx_free  = !rx_valid_q || port.rx_ready;

    always_comb begin
        dq_d = dq_q;
        if (trans_hs) begin
            dq_d = 8'(port.trans.len);
            dq_d[hyper_pkg::CmdWriteBit] = port.trans.write;
        end else if (state_q == hyper_pkg::PHY_CMD) begin
            dq_d = (cnt_q == '0) ? trans_q.addr[15:8] : trans_q.addr[7:0];
        end else if (tx_hs) begin
            dq_d = port.tx.data[15:8];
        end else if (state_q == hyper_pkg::PHY_WDATA && half_q) begin
            dq_d = byte_q;
        end
    end

    always_ff @(posedge clk_sys_i) begin
        dq_q <= dq_d;
        if (trans_hs) begin
            trans_q <= port.trans;
        end
        if (tx_hs) begin
            byte_q <= port.tx.data[7:0];
        end else if (rd_hi) begin
            byte_q <= hyper_dq_i;
        end
        if (rd_lo) begin
            rx_q.data <= {byte_q, hyper_dq_i};
            rx_q.last <= rd_last;
        end
    end

    always_ff @(posedge clk_sys_i) begin
        if (!rst_n_i) begin
            state_q    <= hyper_pkg::PHY_IDLE;
            cs_n_q     <= 1'b1;
            ck_q       <= 1'b0;
            oe_q       <= 1'b0;
            rx_valid_q <= 1'b0;
            cnt_q      <= '0;
            wcnt_q     <= '0;
            half_q     <= 1'b0;
        end else begin
            if (port.rx_valid && port.rx_ready) begin
                rx_valid_q <= 1'b0;
            end
            case (state_q)
                hyper_pkg::PHY_IDLE: begin
                    if (trans_hs) begin
                        state_q <= hyper_pkg::PHY_CMD;
                        cs_n_q  <= 1'b0;
                        ck_q    <= 1'b1;
                        oe_q    <= 1'b1;
                        cnt_q   <= '0;
                        wcnt_q  <= '0;
                        half_q  <= 1'b0;
                    end
                end
                hyper_pkg::PHY_CMD: begin
                    cnt_q <= cnt_q + 1'b1;
                    if (cnt_q == CntWidth'(2)) begin
                        cnt_q <= '0;
                        if (trans_q.write) begin
                            state_q <= hyper_pkg::PHY_WDATA;
                            ck_q    <= 1'b0;
                        end else begin
                            state_q <= hyper_pkg::PHY_LATENCY;
                            oe_q    <= 1'b0;
                        end
                    end
                end
                hyper_pkg::PHY_LATENCY: begin
                    cnt_q <= cnt_q + 1'b1;
                    if (cnt_q == CntWidth'(LatencyCycles - 1)) begin
                        state_q <= hyper_pkg::PHY_RDATA;
                    end
                end
                hyper_pkg::PHY_WDATA: begin
                    if (!half_q) begin
                        // Stall the bus clock until a beat is offered
                        ck_q <= port.tx_valid;
                        if (tx_hs) begin
                            half_q <= 1'b1;
                            wcnt_q <= wcnt_q + 1'b1;
                        end
                    end else begin
                        ck_q   <= 1'b1;
                        half_q <= 1'b0;
                        if (wcnt_q == hyper_pkg::len_t'(trans_q.len + 1'b1)) begin
                            state_q <= hyper_pkg::PHY_RECOVER;
                            cnt_q   <= '0;
                        end
                    end
                end
                hyper_pkg::PHY_RDATA: begin
                    if (rd_hi) begin
                        half_q <= 1'b1;
                        ck_q   <= rx_free;
                    end else if (rd_lo) begin
                        half_q     <= 1'b0;
                        rx_valid_q <= 1'b1;
                        wcnt_q     <= wcnt_q + 1'b1;
                        if (rd_last) begin
                            state_q <= hyper_pkg::PHY_RECOVER;
                            cs_n_q  <= 1'b1;
                            ck_q    <= 1'b0;
                            cnt_q   <= CntWidth'(1);
                        end
                    end else begin
                        // Low byte waits for a free read slot
                        ck_q <= rx_free;
                    end
                end
                hyper_pkg::PHY_RECOVER: begin
                    cs_n_q <= 1'b1;
                    ck_q   <= 1'b0;
                    oe_q   <= 1'b0;
                    if (cnt_q != CntWidth'(hyper_pkg::RecoveryCycles)) begin
                        cnt_q <= cnt_q + 1'b1;
                    end else if (!rx_valid_q) begin
                        state_q <= hyper_pkg::PHY_IDLE;
                    end
                end
                default: begin
                    state_q <= hyper_pkg::PHY_IDLE;
                end
            endcase
        end
    end

    assign hyper_cs_n_o  = cs_n_q;
    assign hyper_ck_o    = ck_q;
    assign hyper_dq_o    = dq_q;
    assign hyper_dq_oe_o = oe_q;

endmodule

/* hyper_top.sv */
module hyper_top #(
    parameter int unsigned LatencyCycles = 4
) (
    input  logic               clk_sys_i,
    input  logic               rst_n_i,
    // System bus requester
    input  logic               sys_trans_valid_i,
    output logic               sys_trans_ready_o,
    input  logic               sys_trans_write_i,
    input  hyper_pkg::addr_t   sys_trans_addr_i,
    input  hyper_pkg::len_t    sys_trans_len_i,
    input  logic               sys_tx_valid_i,
    output logic               sys_tx_ready_o,
    input  hyper_pkg::word_t   sys_tx_data_i,
    output logic               sys_rx_valid_o,
    input  logic               sys_rx_ready_i,
    output hyper_pkg::word_t   sys_rx_data_o,
    output logic               sys_rx_last_o,
    // uDMA requester
    input  logic               dma_trans_valid_i,
    output logic               dma_trans_ready_o,
    input  logic               dma_trans_write_i,
    input  hyper_pkg::addr_t   dma_trans_addr_i,
    input  hyper_pkg::len_t    dma_trans_len_i,
    input  logic               dma_tx_valid_i,
    output logic               dma_tx_ready_o,
    input  hyper_pkg::word_t   dma_tx_data_i,
    output logic               dma_rx_valid_o,
    input  logic               dma_rx_ready_i,
    output hyper_pkg::word_t   dma_rx_data_o,
    output logic               dma_rx_last_o,
    // HyperBus
    output logic               hyper_cs_n_o,
    output logic               hyper_ck_o,
    output logic [7:0]         hyper_dq_o,
    output logic               hyper_dq_oe_o,
    input  logic [7:0]         hyper_dq_i
);

    hyper_pkg::rx_beat_t sys_rx;
    hyper_pkg::rx_beat_t dma_rx;

    hyper_port_if sys_if ();
    hyper_port_if dma_if ();
    hyper_port_if phy_if ();

    assign sys_rx_data_o = sys_rx.data;
    assign sys_rx_last_o = sys_rx.last;
    assign dma_rx_data_o = dma_rx.data;
    assign dma_rx_last_o = dma_rx.last;

    hyper_host_port i_sys_port (
        .clk_sys_i     ( clk_sys_i                                              ),
        .rst_n_i       ( rst_n_i                                                ),
        .trans_valid_i ( sys_trans_valid_i                                      ),
        .trans_ready_o ( sys_trans_ready_o                                      ),
        .trans_i       ( {sys_trans_write_i, sys_trans_addr_i, sys_trans_len_i} ),
        .tx_valid_i    ( sys_tx_valid_i                                         ),
        .tx_ready_o    ( sys_tx_ready_o                                         ),
        .tx_data_i     ( sys_tx_data_i                                          ),
        .rx_valid_o    ( sys_rx_valid_o                                         ),
        .rx_ready_i    ( sys_rx_ready_i                                         ),
        .rx_o          ( sys_rx                                                 ),
        .port          ( sys_if.host                                            )
    );

    hyper_host_port i_dma_port (
        .clk_sys_i     ( clk_sys_i                                              ),
        .rst_n_i       ( rst_n_i                                                ),
        .trans_valid_i ( dma_trans_valid_i                                      ),
        .trans_ready_o ( dma_trans_ready_o                                      ),
        .trans_i       ( {dma_trans_write_i, dma_trans_addr_i, dma_trans_len_i} ),
        .tx_valid_i    ( dma_tx_valid_i                                         ),
        .tx_ready_o    ( dma_tx_ready_o                                         ),
        .tx_data_i     ( dma_tx_data_i                                          ),
        .rx_valid_o    ( dma_rx_valid_o                                         ),
        .rx_ready_i    ( dma_rx_ready_i                                         ),
        .rx_o          ( dma_rx                                                 ),
        .port          ( dma_if.host                                            )
    );

    hyper_arbiter i_arbiter (
        .clk_sys_i ( clk_sys_i   ),
        .rst_n_i   ( rst_n_i     ),
        .sys       ( sys_if.bus  ),
        .dma       ( dma_if.bus  ),
        .phy       ( phy_if.host )
    );

    hyper_phy #(
        .LatencyCycles ( LatencyCycles )
    ) i_phy (
        .clk_sys_i     ( clk_sys_i     ),
        .rst_n_i       ( rst_n_i       ),
        .port          ( phy_if.bus    ),
        .hyper_cs_n_o  ( hyper_cs_n_o  ),
        .hyper_ck_o    ( hyper_ck_o    ),
        .hyper_dq_o    ( hyper_dq_o    ),
        .hyper_dq_oe_o ( hyper_dq_oe_o ),
        .hyper_dq_i    ( hyper_dq_i    )
    );

endmodule

/* hyper_arbiter_props.sv */
module hyper_arbiter_props (
    input logic clk_sys_i,
    input logic rst_n_i,
    input logic cs_n_i,
    input logic dq_oe_i,
    input logic sys_rx_valid_i,
    input logic dma_rx_valid_i
);

    timeunit 1ns;
    timeprecision 1ps;

    // Data lines driven only inside a chip-select window
    oe_inside_cs: assert property (@(posedge clk_sys_i) disable iff (!rst_n_i)
        dq_oe_i |-> !cs_n_i)
        else $error("dq_oe high while chip select is high");

    rx_one_port: assert property (@(posedge clk_sys_i) disable iff (!rst_n_i)
        !(sys_rx_valid_i && dma_rx_valid_i))
        else $error("read data offered to both ports at once");

    cs_recovery: assert property (@(posedge clk_sys_i) disable iff (!rst_n_i)
        $rose(cs_n_i) |-> cs_n_i [*hyper_pkg::RecoveryCycles])
        else $error("chip select high for less than the recovery gap");

endmodule

bind hyper_top hyper_arbiter_props i_arbiter_props (
    .clk_sys_i      ( clk_sys_i      ),
    .rst_n_i        ( rst_n_i        ),
    .cs_n_i         ( hyper_cs_n_o   ),
    .dq_oe_i        ( hyper_dq_oe_o  ),
    .sys_rx_valid_i ( sys_rx_valid_o ),
    .dma_rx_valid_i ( dma_rx_valid_o )
);

/* tb_hyper_top.sv */
module tb_hyper_top;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int unsigned LatencyCycles = 4;
    localparam int          WaitLimit     = 500;

    logic              clk_sys_i;
    logic              rst_n_i;

    // Requester signals, index 0 is sys and index 1 is dma
    logic [1:0]        trans_valid;
    logic [1:0]        trans_ready;
    logic [1:0]        trans_write;
    hyper_pkg::addr_t  trans_addr [2];
    hyper_pkg::len_t   trans_len [2];
    logic [1:0]        tx_valid;
    logic [1:0]        tx_ready;
    hyper_pkg::word_t  tx_data [2];
    logic [1:0]        rx_valid;
    logic [1:0]        rx_ready;
    hyper_pkg::word_t  rx_data [2];
    logic [1:0]        rx_last;

    logic              hyper_cs_n;
    logic              hyper_ck;
    logic [7:0]        hyper_dq_o;
    logic              hyper_dq_oe;
    logic [7:0]        hyper_dq_i;

    // HyperBus device model state
    hyper_pkg::word_t  dev_mem [256];
    hyper_pkg::trans_t dev_cmd;
    hyper_pkg::trans_t cmd_seen [$];
    hyper_pkg::word_t  dev_word;
    logic [7:0]        cmd_b0;
    logic [7:0]        cmd_b1;
    logic [7:0]        hi_byte;
    logic [7:0]        wr_idx;
    int                byte_cnt;
    int                data_idx;
    logic              in_burst;

    hyper_pkg::word_t  ref_mem [256];
    hyper_pkg::word_t  burst [16];
    logic [31:0]       rng_state;
    int                err_cnt;
    int                timeout_cnt;

    hyper_top #(
        .LatencyCycles ( LatencyCycles )
    ) UUT (
        .clk_sys_i         ( clk_sys_i      ),
        .rst_n_i           ( rst_n_i        ),
        .sys_trans_valid_i ( trans_valid[0] ),
        .sys_trans_ready_o ( trans_ready[0] ),
        .sys_trans_write_i ( trans_write[0] ),
        .sys_trans_addr_i  ( trans_addr[0]  ),
        .sys_trans_len_i   ( trans_len[0]   ),
        .sys_tx_valid_i    ( tx_valid[0]    ),
        .sys_tx_ready_o    ( tx_ready[0]    ),
        .sys_tx_data_i     ( tx_data[0]     ),
        .sys_rx_valid_o    ( rx_valid[0]    ),
        .sys_rx_ready_i    ( rx_ready[0]    ),
        .sys_rx_data_o     ( rx_data[0]     ),
        .sys_rx_last_o     ( rx_last[0]     ),
        .dma_trans_valid_i ( trans_valid[1] ),
        .dma_trans_ready_o ( trans_ready[1] ),
        .dma_trans_write_i ( trans_write[1] ),
        .dma_trans_addr_i  ( trans_addr[1]  ),
        .dma_trans_len_i   ( trans_len[1]   ),
        .dma_tx_valid_i    ( tx_valid[1]    ),
        .dma_tx_ready_o    ( tx_ready[1]    ),
        .dma_tx_data_i     ( tx_data[1]     ),
        .dma_rx_valid_o    ( rx_valid[1]    ),
        .dma_rx_ready_i    ( rx_ready[1]    ),
        .dma_rx_data_o     ( rx_data[1]     ),
        .dma_rx_last_o     ( rx_last[1]     ),
        .hyper_cs_n_o      ( hyper_cs_n     ),
        .hyper_ck_o        ( hyper_ck       ),
        .hyper_dq_o        ( hyper_dq_o     ),
        .hyper_dq_oe_o     ( hyper_dq_oe    ),
        .hyper_dq_i        ( hyper_dq_i     )
    );

    always #5 clk_sys_i = ~clk_sys_i;

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x ^= x << 13;
        x ^= x >> 17;
        x ^= x << 5;
        return x;
    endfunction

    function automatic hyper_pkg::word_t fill_word(input logic [7:0] idx);
        return {idx ^ 8'h5a, ~idx};
    endfunction

    // Word k of a burst sits at address A+k
    function automatic logic [7:0] word_index(input hyper_pkg::addr_t addr, input int k);
        return 8'(int'(addr[7:0]) + k);
    endfunction

    function automatic int window_bytes(input hyper_pkg::trans_t t);
        int n;
        n = 3 + 2 * (int'(t.len) + 1);
        if (!t.write) begin
            n += LatencyCycles;
        end
        return n;
    endfunction

    task automatic report_timeout(input string what);
        timeout_cnt++;
        $display("timeout at %0t: %s", $time, what);
    endtask

    task automatic check_bit(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            err_cnt++;
            $display("mismatch at %0t: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    task automatic check_count(input int got, input int exp, input string what);
        if (got != exp) begin
            err_cnt++;
            $display("mismatch at %0t: %s is %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic check_word(input hyper_pkg::word_t got, input hyper_pkg::word_t exp,
                              input string what);
        if (got !== exp) begin
            err_cnt++;
            $display("mismatch at %0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_cmd(input hyper_pkg::trans_t got, input hyper_pkg::trans_t exp);
        if (got !== exp) begin
            err_cnt++;
            $display({"mismatch at %0t: bus command write=%b addr=%h len=%0d,",
                      " expected write=%b addr=%h len=%0d"},
                     $time, got.write, got.addr, got.len, exp.write, exp.addr, exp.len);
        end
    endtask

    // Device model, one byte per clocked cycle while chip select is low
    always @(negedge clk_sys_i) begin
        if (hyper_cs_n === 1'b1) begin
            if (in_burst) begin
                check_count(byte_cnt, window_bytes(dev_cmd), "bytes in a chip-select window");
            end
            in_burst = 1'b0;
            byte_cnt = 0;
        end else if (hyper_cs_n === 1'b0 && hyper_ck === 1'b1) begin
            in_burst = 1'b1;
            check_bit(hyper_dq_oe, byte_cnt < 3 || dev_cmd.write, "dq_oe on a clocked byte");
            case (byte_cnt)
                0: cmd_b0 = hyper_dq_o;
                1: cmd_b1 = hyper_dq_o;
                2: begin
                    dev_cmd.write = cmd_b0[hyper_pkg::CmdWriteBit];
                    dev_cmd.addr  = {cmd_b1, hyper_dq_o};
                    dev_cmd.len   = cmd_b0[3:0];
                    check_count(int'(cmd_b0[6:4]), 0, "reserved bits of command byte 0");
                    cmd_seen.push_back(dev_cmd);
                end
                default: begin
                    if (dev_cmd.write) begin
                        data_idx = byte_cnt - 3;
                        if (data_idx % 2 == 0) begin
                            hi_byte = hyper_dq_o;
                        end else begin
                            wr_idx          = word_index(dev_cmd.addr, data_idx / 2);
                            dev_mem[wr_idx] = {hi_byte, hyper_dq_o};
                        end
                    end else if (byte_cnt >= 3 + LatencyCycles) begin
                        // High byte first
                        data_idx   = byte_cnt - 3 - LatencyCycles;
                        dev_word   = dev_mem[word_index(dev_cmd.addr, data_idx / 2)];
                        hyper_dq_i = (data_idx % 2 == 0) ? dev_word[15:8] : dev_word[7:0];
                    end
                end
            endcase
            byte_cnt++;
        end
    end

    task automatic issue_trans(input hyper_pkg::req_sel_e req, input hyper_pkg::trans_t t);
        int n;
        trans_valid[req] = 1'b1;
        trans_write[req] = t.write;
        trans_addr[req]  = t.addr;
        trans_len[req]   = t.len;
        n = 0;
        while (trans_ready[req] !== 1'b1 && n < WaitLimit) begin
            @(negedge clk_sys_i);
            n++;
        end
        if (trans_ready[req] !== 1'b1) begin
            report_timeout($sformatf("port %s never accepted a transaction", req.name()));
        end
        @(negedge clk_sys_i);
        trans_valid[req] = 1'b0;
    endtask

    task automatic send_words(input hyper_pkg::req_sel_e req, input int n_words,
                              input int stall_at, input int stall_len);
        int k;
        int n;
        for (k = 0; k < n_words; k++) begin
            if (k == stall_at) begin
                tx_valid[req] = 1'b0;
                repeat (stall_len) @(negedge clk_sys_i);
            end
            tx_valid[req] = 1'b1;
            tx_data[req]  = burst[k];
            n = 0;
            while (tx_ready[req] !== 1'b1 && n < WaitLimit) begin
                @(negedge clk_sys_i);
                n++;
            end
            if (tx_ready[req] !== 1'b1) begin
                report_timeout($sformatf("port %s never took write word %0d", req.name(), k));
            end
            @(negedge clk_sys_i);
        end
        tx_valid[req] = 1'b0;
    endtask

    task automatic recv_words(input hyper_pkg::req_sel_e req, input hyper_pkg::addr_t addr,
                              input int n_words, input int stall);
        int k;
        int n;
        for (k = 0; k < n_words; k++) begin
            rx_ready[req] = 1'b0;
            repeat (stall) @(negedge clk_sys_i);
            n = 0;
            while (rx_valid[req] !== 1'b1 && n < WaitLimit) begin
                @(negedge clk_sys_i);
                n++;
            end
            if (rx_valid[req] !== 1'b1) begin
                report_timeout($sformatf("port %s never returned read word %0d", req.name(), k));
            end else begin
                check_word(rx_data[req], ref_mem[word_index(addr, k)], "read data");
                check_bit(rx_last[req], k == n_words - 1, "rx_last");
            end
            rx_ready[req] = 1'b1;
            @(negedge clk_sys_i);
        end
        rx_ready[req] = 1'b0;
    endtask

    task automatic expect_cmd(input hyper_pkg::trans_t t);
        int n;
        n = 0;
        while (cmd_seen.size() == 0 && n < WaitLimit) begin
            @(negedge clk_sys_i);
            n++;
        end
        if (cmd_seen.size() == 0) begin
            report_timeout("no command appeared on the bus");
        end else begin
            check_cmd(cmd_seen.pop_front(), t);
        end
    endtask

    task automatic write_burst(input hyper_pkg::req_sel_e req, input hyper_pkg::addr_t addr,
                               input int n_words, input int stall_at, input int stall_len);
        hyper_pkg::trans_t t;
        int k;
        for (k = 0; k < n_words; k++) begin
            rng_state = xorshift32(rng_state);
            burst[k]  = rng_state[15:0];
            ref_mem[word_index(addr, k)] = burst[k];
        end
        t = '{write: 1'b1, addr: addr, len: hyper_pkg::len_t'(n_words - 1)};
        issue_trans(req, t);
        send_words(req, n_words, stall_at, stall_len);
        expect_cmd(t);
    endtask

    task automatic read_burst(input hyper_pkg::req_sel_e req, input hyper_pkg::addr_t addr,
                              input int n_words, input int stall);
        hyper_pkg::trans_t t;
        t = '{write: 1'b0, addr: addr, len: hyper_pkg::len_t'(n_words - 1)};
        issue_trans(req, t);
        recv_words(req, addr, n_words, stall);
        expect_cmd(t);
    endtask

    task automatic test_reset_state;
        check_bit(hyper_cs_n, 1'b1, "cs_n in reset");
        check_bit(hyper_ck, 1'b0, "bus clock in reset");
        check_bit(hyper_dq_oe, 1'b0, "dq_oe in reset");
        check_bit(rx_valid[0], 1'b0, "sys rx_valid in reset");
        check_bit(rx_valid[1], 1'b0, "dma rx_valid in reset");
        check_bit(trans_ready[0], 1'b0, "sys trans_ready in reset");
        check_bit(trans_ready[1], 1'b0, "dma trans_ready in reset");
    endtask

    task automatic test_single_word;
        write_burst(hyper_pkg::REQ_SYS, 16'h1234, 1, -1, 0);
        read_burst(hyper_pkg::REQ_SYS, 16'h1234, 1, 0);
    endtask

    task automatic test_dma_burst;
        write_burst(hyper_pkg::REQ_DMA, 16'h4080, 4, -1, 0);
        read_burst(hyper_pkg::REQ_SYS, 16'h4080, 4, 0);
    endtask

    // Both requesters in the same cycle, sys is served first
    task automatic test_arbitration;
        hyper_pkg::trans_t sys_t;
        hyper_pkg::trans_t dma_t;
        int n;
        sys_t = '{write: 1'b0, addr: 16'h1234, len: 4'd0};
        dma_t = '{write: 1'b0, addr: 16'h4081, len: 4'd2};
        trans_write = 2'b00;
        trans_addr[0] = sys_t.addr;
        trans_len[0]  = sys_t.len;
        trans_addr[1] = dma_t.addr;
        trans_len[1]  = dma_t.len;
        trans_valid   = 2'b11;
        n = 0;
        while (trans_ready !== 2'b11 && n < WaitLimit) begin
            @(negedge clk_sys_i);
            n++;
        end
        if (trans_ready !== 2'b11) begin
            report_timeout("the two ports never accepted their transactions together");
        end
        @(negedge clk_sys_i);
        trans_valid = 2'b00;
        recv_words(hyper_pkg::REQ_SYS, sys_t.addr, 1, 0);
        recv_words(hyper_pkg::REQ_DMA, dma_t.addr, 3, 0);
        expect_cmd(sys_t);
        expect_cmd(dma_t);
    endtask

    task automatic test_write_stall;
        write_burst(hyper_pkg::REQ_SYS, 16'h00f0, 8, 3, 6);
        read_burst(hyper_pkg::REQ_SYS, 16'h00f0, 8, 0);
    endtask

    task automatic test_read_stall;
        read_burst(hyper_pkg::REQ_DMA, 16'h00f0, 8, 4);
    endtask

    initial begin
        int i;
        clk_sys_i   = 1'b0;
        rst_n_i     = 1'b0;
        trans_valid = '0;
        trans_write = '0;
        tx_valid    = '0;
        rx_ready    = '0;
        hyper_dq_i  = '0;
        for (i = 0; i < 2; i++) begin
            trans_addr[i] = '0;
            trans_len[i]  = '0;
            tx_data[i]    = '0;
        end
        for (i = 0; i < 256; i++) begin
            dev_mem[i] = fill_word(8'(i));
            ref_mem[i] = fill_word(8'(i));
        end
        dev_cmd     = '0;
        byte_cnt    = 0;
        in_burst    = 1'b0;
        rng_state   = 32'hb560_c764;
        err_cnt     = 0;
        timeout_cnt = 0;

        repeat (4) @(negedge clk_sys_i);
        test_reset_state();
        rst_n_i = 1'b1;
        @(negedge clk_sys_i);

        test_single_word();
        test_dma_burst();
        test_arbitration();
        test_write_stall();
        test_read_stall();

        repeat (4) @(negedge clk_sys_i);
        $display("errors: %0d mismatches, %0d timeouts", err_cnt, timeout_cnt);
        if (err_cnt == 0 && timeout_cnt == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

/* compile.f */
hyper_pkg.sv
hyper_port_if.sv
hyper_host_port.sv
hyper_arbiter.sv
hyper_phy.sv
hyper_top.sv
hyper_arbiter_props.sv
tb_hyper_top.sv

/* Bender.yml */
package:
  name: hyper_bus

sources:
  - hyper_pkg.sv
  - hyper_port_if.sv
  - hyper_host_port.sv
  - hyper_arbiter.sv
  - hyper_phy.sv
  - hyper_top.sv
  - target: test
    files:
      - hyper_arbiter_props.sv
      - tb_hyper_top.sv
